/* hdl/ex_lsu_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU shared definitions: opcode bus layout, size codes, widths and
// the data word union used by the store and load formatters
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package ex_lsu_pkg;

   // Datapath widths
   localparam int DW = 32;
   localparam int AW = 32;

   // Opcode bus carries load, store, sign_ext, barr and a 3-bit size
   // Barr sits at bit 3 and is ignored by this unit
   localparam int IOPW         = 7;
   localparam int OPC_LOAD     = 0;
   localparam int OPC_STORE    = 1;
   localparam int OPC_SIGN_EXT = 2;
   localparam int OPC_SIZE_LSB = 4;   // Size occupies bits 6:4

   // Access size codes, anything else means no access
   localparam logic [2:0] SIZE_BYTE = 3'd1;
   localparam logic [2:0] SIZE_HALF = 3'd2;
   localparam logic [2:0] SIZE_WORD = 3'd3;

   // Data RAM word address, indexed by vaddr[9:2]
   localparam int DMEM_AW = 8;

   // One data word seen three ways
   typedef union packed {
      logic [DW-1:0]           w;   // Whole word
      logic [DW/8-1:0][7:0]    b;   // Byte lanes, b[0] is the low byte
      logic [DW/16-1:0][15:0]  h;   // Halfword lanes
   } lsu_word_u;

endpackage

/* hdl/lsu_ctrl.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU control: opcode decode, alignment check, request gating and the
// stage-one registers
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_ctrl
   import ex_lsu_pkg::*;
(
   input                clk,
   input                rst,
   input                stall,
   input                flush,
   input                ex_valid,
   input  [IOPW-1:0]    ex_lsu_opc_bus,
   input  [DW-1:0]      add_sum,
   output               dmem_re,
   output               dmem_we,
   output logic         s1_valid,
   output logic         s1_ealign,
   output logic         s1_sign_ext,
   output logic [2:0]   s1_size,
   output logic [AW-1:0] s1_vaddr
);
   wire        load     = ex_lsu_opc_bus[OPC_LOAD];
   wire        store    = ex_lsu_opc_bus[OPC_STORE];
   wire        sign_ext = ex_lsu_opc_bus[OPC_SIGN_EXT];
   wire [2:0]  size     = ex_lsu_opc_bus[OPC_SIZE_LSB +: 3];
   wire        misalign;
   wire        accept;

   // Word needs both low bits clear, halfword needs bit 0 clear
   assign misalign = ((size == SIZE_WORD) & (|add_sum[1:0])) |
                     ((size == SIZE_HALF) & add_sum[0]);

   assign accept  = ex_valid & (load | store) & ~flush & ~stall;

   assign dmem_re = accept & load;
   assign dmem_we = accept & store & ~misalign;   // Misaligned stores never reach the RAM

   // Control state
   always_ff @(posedge clk) begin
      if (rst) begin
         s1_valid  <= 1'b0;
         s1_ealign <= 1'b0;
      end else if (!stall) begin
         s1_valid  <= accept;
         s1_ealign <= accept & misalign;
      end
   end

   // Payload follows the pipe whenever it advances
   always_ff @(posedge clk) begin
      if (!stall) begin
         s1_size     <= size;
         s1_sign_ext <= sign_ext;
         s1_vaddr    <= add_sum[AW-1:0];
      end
   end

endmodule

/* hdl/lsu_store_fmt.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Store formatter: lane replication and byte write mask
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_store_fmt
   import ex_lsu_pkg::*;
(
   input  [IOPW-1:0]       ex_lsu_opc_bus,
   input  [DW-1:0]         add_sum,
   input  [DW-1:0]         ex_operand2,
   output [DW-1:0]         wdat,
   output logic [DW/8-1:0] wmsk
);
   wire [2:0]  size = ex_lsu_opc_bus[OPC_SIZE_LSB +: 3];
   lsu_word_u  wd;

   // Put the operand on every lane it could land in
   always_comb begin
      case (size)
         SIZE_BYTE: wd.b = {(DW/8){ex_operand2[7:0]}};
         SIZE_HALF: wd.h = {(DW/16){ex_operand2[15:0]}};
         SIZE_WORD: wd.w = ex_operand2;
         default:   wd.w = '0;
      endcase
   end

   assign wdat = wd.w;

   always_comb begin
      case (size)
         SIZE_BYTE: wmsk = 4'b0001 << add_sum[1:0];
         SIZE_HALF: wmsk = add_sum[1] ? 4'b1100 : 4'b0011;
         SIZE_WORD: wmsk = 4'b1111;
         default:   wmsk = 4'b0000;   // No access size, touch nothing
      endcase
   end

endmodule

/* hdl/lsu_dmem.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Tightly coupled data RAM with byte write enables
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_dmem
   import ex_lsu_pkg::*;
(
   input                     clk,
   input                     re,
   input                     we,
   input  [DMEM_AW-1:0]      addr,
   input  [DW-1:0]           wdat,
   input  [DW/8-1:0]         wmsk,
   output logic [DW-1:0]     rdat
);
   logic [DW-1:0] mem [0:(1<<DMEM_AW)-1];

   // Byte lanes written independently
   always_ff @(posedge clk) begin
      if (we) begin
         for (int i = 0; i < DW/8; i++) begin
            if (wmsk[i])
               mem[addr][8*i +: 8] <= wdat[8*i +: 8];
         end
      end
   end

   // Read register only moves on a read, so the last load result
   // stays put while the pipe is stalled
   always_ff @(posedge clk) begin
      if (re)
         rdat <= mem[addr];
   end

endmodule

/* hdl/lsu_load_fmt.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load formatter: lane select and sign or zero extension
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module lsu_load_fmt
   import ex_lsu_pkg::*;
(
   input  [DW-1:0]         rdat,
   input  [AW-1:0]         s1_vaddr,
   input  [2:0]            s1_size,
   input                   s1_sign_ext,
   output logic [DW-1:0]   lsu_dout
);
   lsu_word_u  rd;
   logic [7:0]  dout_8b;
   logic [15:0] dout_16b;

   assign rd = rdat;

   // Lane picked by the low address bits of the request
   assign dout_8b  = rd.b[s1_vaddr[1:0]];
   assign dout_16b = rd.h[s1_vaddr[1]];

   always_comb begin
      case (s1_size)
         SIZE_BYTE:
            lsu_dout = {{(DW-8){s1_sign_ext & dout_8b[7]}}, dout_8b};
         SIZE_HALF:
            lsu_dout = {{(DW-16){s1_sign_ext & dout_16b[15]}}, dout_16b};
         SIZE_WORD:
            lsu_dout = rd.w;
         default:
            lsu_dout = '0;
      endcase
   end

endmodule

/* hdl/ex_lsu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store unit top: control, store formatting, data RAM and load
// formatting in a two-stage datapath
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ex_lsu
   import ex_lsu_pkg::*;
(
   input                clk,
   input                rst,
   input                stall,
   input                flush,
   input                ex_valid,
   input  [IOPW-1:0]    ex_lsu_opc_bus,
   input  [DW-1:0]      add_sum,
   input  [DW-1:0]      ex_operand2,
   output               lsu_valid,
   output               lsu_ealign,
   output [AW-1:0]      lsu_vaddr,
   output [DW-1:0]      lsu_dout
);
   wire                 dmem_re;
   wire                 dmem_we;
   wire [DW-1:0]        wdat;
   wire [DW/8-1:0]      wmsk;
   wire [DW-1:0]        rdat;
   wire                 s1_sign_ext;
   wire [2:0]           s1_size;

   lsu_ctrl u_ctrl (
      .clk              (clk),
      .rst              (rst),
      .stall            (stall),
      .flush            (flush),
      .ex_valid         (ex_valid),
      .ex_lsu_opc_bus   (ex_lsu_opc_bus),
      .add_sum          (add_sum),
      .dmem_re          (dmem_re),
      .dmem_we          (dmem_we),
      .s1_valid         (lsu_valid),
      .s1_ealign        (lsu_ealign),
      .s1_sign_ext      (s1_sign_ext),
      .s1_size          (s1_size),
      .s1_vaddr         (lsu_vaddr)
   );

   lsu_store_fmt u_store_fmt (
      .ex_lsu_opc_bus   (ex_lsu_opc_bus),
      .add_sum          (add_sum),
      .ex_operand2      (ex_operand2),
      .wdat             (wdat),
      .wmsk             (wmsk)
   );

   lsu_dmem u_dmem (
      .clk              (clk),
      .re               (dmem_re),
      .we               (dmem_we),
      .addr             (add_sum[DMEM_AW+1:2]),   // Word index, upper bits ignored
      .wdat             (wdat),
      .wmsk             (wmsk),
      .rdat             (rdat)
   );

   lsu_load_fmt u_load_fmt (
      .rdat             (rdat),
      .s1_vaddr         (lsu_vaddr),
      .s1_size          (s1_size),
      .s1_sign_ext      (s1_sign_ext),
      .lsu_dout         (lsu_dout)
   );

endmodule

/* test/ex_lsu_props.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU control properties, bound onto the top level
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module ex_lsu_props
   import ex_lsu_pkg::*;
(
   input          clk,
   input          rst,
   input          stall,
   input          lsu_valid,
   input          lsu_ealign,
   input [AW-1:0] lsu_vaddr,
   input [DW-1:0] lsu_dout
);
   // Synchronous reset clears valid at the edge it is seen
   a_reset_valid: assert property (@(posedge clk) rst |=> !lsu_valid)
      else $error("lsu_valid high after a reset edge");

   // A stalled edge freezes every output
   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      stall |=> (lsu_valid === $past(lsu_valid)) && (lsu_ealign === $past(lsu_ealign)) &&
                (lsu_vaddr === $past(lsu_vaddr)) && (lsu_dout === $past(lsu_dout)))
      else $error("Outputs moved across a stalled edge");

   a_ealign_valid: assert property (@(posedge clk) disable iff (rst)
      lsu_ealign |-> lsu_valid)
      else $error("lsu_ealign high without lsu_valid");

endmodule

bind ex_lsu ex_lsu_props u_props (
   .clk        (clk),
   .rst        (rst),
   .stall      (stall),
   .lsu_valid  (lsu_valid),
   .lsu_ealign (lsu_ealign),
   .lsu_vaddr  (lsu_vaddr),
   .lsu_dout   (lsu_dout)
);

/* test/tb_ex_lsu.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// LSU testbench: table of requests checked against a byte-array model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_ex_lsu
   import ex_lsu_pkg::*;
();
   typedef struct packed {
      logic          ex_valid;
      logic          flush;
      logic          stall;
      logic          load;
      logic          store;
      logic          sign_ext;
      logic [2:0]    size;
      logic [AW-1:0] addr;
      logic [DW-1:0] data;
      logic          ealign;   // Expected misalignment of the access
   } row_t;

   logic            clk;
   logic            rst;
   logic            stall;
   logic            flush;
   logic            ex_valid;
   logic [IOPW-1:0] ex_lsu_opc_bus;
   logic [DW-1:0]   add_sum;
   logic [DW-1:0]   ex_operand2;
   wire             lsu_valid;
   wire             lsu_ealign;
   wire  [AW-1:0]   lsu_vaddr;
   wire  [DW-1:0]   lsu_dout;

   row_t            rows[$];
   logic [7:0]      model_mem [0:1023];   // Byte image of the 256-word RAM
   logic            exp_valid;
   logic            exp_ealign;
   logic [AW-1:0]   exp_vaddr;
   logic [DW-1:0]   exp_dout;
   logic            vaddr_known;
   logic            dout_known;

   ex_lsu ex_lsu_i (
      .clk            (clk),
      .rst            (rst),
      .stall          (stall),
      .flush          (flush),
      .ex_valid       (ex_valid),
      .ex_lsu_opc_bus (ex_lsu_opc_bus),
      .add_sum        (add_sum),
      .ex_operand2    (ex_operand2),
      .lsu_valid      (lsu_valid),
      .lsu_ealign     (lsu_ealign),
      .lsu_vaddr      (lsu_vaddr),
      .lsu_dout       (lsu_dout)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   initial begin
      rst = 1'b1;
      repeat (8) @(posedge clk);
      #1;
      rst = 1'b0;
   end

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         $display("CHECK FAILED time=%0t signal=%s expected=%b got=%b",
                  $time, name, exp, got);
         $display("RESULT: FAIL");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic check_word(input string name, input logic [DW-1:0] exp,
                             input logic [DW-1:0] got);
      if (got !== exp) begin
         $display("CHECK FAILED time=%0t signal=%s expected=%h got=%h",
                  $time, name, exp, got);
         $display("RESULT: FAIL");
         $fatal(1, "Output mismatch");
      end
   endtask

   task automatic add_row(input logic ev, input logic fl, input logic st, input logic ld,
                          input logic sto, input logic sx, input logic [2:0] sz,
                          input logic [AW-1:0] addr, input logic ea);
      row_t r;
      r.ex_valid = ev;
      r.flush    = fl;
      r.stall    = st;
      r.load     = ld;
      r.store    = sto;
      r.sign_ext = sx;
      r.size     = sz;
      r.addr     = addr;
      r.data     = sto ? $urandom() : '0;   // Random store data
      r.ealign   = ea;
      rows.push_back(r);
   endtask

   task automatic add_load(input logic [2:0] sz, input logic sx, input logic [AW-1:0] addr,
                           input logic ea);
      add_row(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, sx, sz, addr, ea);
   endtask

   task automatic add_store(input logic [2:0] sz, input logic [AW-1:0] addr, input logic ea);
      add_row(1'b1, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0, sz, addr, ea);
   endtask

   function automatic logic [DW-1:0] model_load(input logic [2:0] sz, input logic sx,
                                                input logic [AW-1:0] a);
      logic [9:0]    base;
      logic [DW-1:0] v;
      base = a[9:0];
      v = '0;
      case (sz)
         SIZE_BYTE: begin
            v[7:0] = model_mem[base];
            if (sx && v[7])
               v[DW-1:8] = '1;
         end
         SIZE_HALF: begin
            base[0] = 1'b0;
            v[15:0] = {model_mem[base + 10'd1], model_mem[base]};
            if (sx && v[15])
               v[DW-1:16] = '1;
         end
         SIZE_WORD: begin
            base[1:0] = 2'b00;
            v = {model_mem[base + 10'd3], model_mem[base + 10'd2],
                 model_mem[base + 10'd1], model_mem[base]};
         end
         default: v = '0;
      endcase
      return v;
   endfunction

   task automatic model_store(input logic [2:0] sz, input logic [AW-1:0] a,
                              input logic [DW-1:0] d);
      logic [9:0] base;
      base = a[9:0];
      case (sz)
         SIZE_BYTE: model_mem[base] = d[7:0];
         SIZE_HALF: begin
            base[0] = 1'b0;
            model_mem[base]         = d[7:0];
            model_mem[base + 10'd1] = d[15:8];
         end
         SIZE_WORD: begin
            base[1:0] = 2'b00;
            for (int k = 0; k < 4; k++)
               model_mem[base + 10'(k)] = d[8*k +: 8];
         end
         default: ;   // No access size
      endcase
   endtask

   // Drives one row and moves the expected outputs to what follows the next edge
   task automatic apply_row(input row_t r);
      logic accept;
      ex_valid       = r.ex_valid;
      flush          = r.flush;
      stall          = r.stall;
      ex_lsu_opc_bus = '0;
      ex_lsu_opc_bus[OPC_LOAD]             = r.load;
      ex_lsu_opc_bus[OPC_STORE]            = r.store;
      ex_lsu_opc_bus[OPC_SIGN_EXT]         = r.sign_ext;
      ex_lsu_opc_bus[OPC_SIZE_LSB +: 3]    = r.size;
      add_sum        = r.addr;
      ex_operand2    = r.data;
      accept = r.ex_valid & (r.load | r.store) & ~r.flush & ~r.stall;
      if (!r.stall) begin   // Under stall every expectation holds
         exp_valid   = accept;
         exp_ealign  = accept & r.ealign;
         exp_vaddr   = r.addr;
         vaddr_known = 1'b1;
         dout_known  = accept & r.load & ~r.ealign;
         if (dout_known)
            exp_dout = model_load(r.size, r.sign_ext, r.addr);
         if (accept && r.store && !r.ealign)
            model_store(r.size, r.addr, r.data);
      end
   endtask

   task automatic check_outputs;
      check_bit("lsu_valid", exp_valid, lsu_valid);
      check_bit("lsu_ealign", exp_ealign, lsu_ealign);
      if (vaddr_known)
         check_word("lsu_vaddr", exp_vaddr, lsu_vaddr);
      if (dout_known)
         check_word("lsu_dout", exp_dout, lsu_dout);
   endtask

   task automatic build_table;
      for (int w = 0; w < 8; w++)
         add_store(SIZE_WORD, 32'(4 * w), 1'b0);
      for (int w = 0; w < 8; w++)
         add_load(SIZE_WORD, 1'b0, 32'(4 * w), 1'b0);
      // Sub-word stores into words 1 and 2, then whole-word readback
      for (int b = 0; b < 4; b++)
         add_store(SIZE_BYTE, 32'(4 + b), 1'b0);
      add_store(SIZE_HALF, 32'h8, 1'b0);
      add_store(SIZE_HALF, 32'hA, 1'b0);
      add_load(SIZE_WORD, 1'b0, 32'h4, 1'b0);
      add_load(SIZE_WORD, 1'b0, 32'h8, 1'b0);
      for (int b = 0; b < 4; b++) begin
         add_load(SIZE_BYTE, 1'b1, 32'(4 + b), 1'b0);
         add_load(SIZE_BYTE, 1'b0, 32'(4 + b), 1'b0);
      end
      add_load(SIZE_HALF, 1'b1, 32'h8, 1'b0);
      add_load(SIZE_HALF, 1'b0, 32'h8, 1'b0);
      add_load(SIZE_HALF, 1'b1, 32'hA, 1'b0);
      add_load(SIZE_HALF, 1'b0, 32'hA, 1'b0);
      // Misaligned accesses
      add_store(SIZE_HALF, 32'hD, 1'b1);
      add_store(SIZE_WORD, 32'hE, 1'b1);
      add_load(SIZE_WORD, 1'b0, 32'hC, 1'b0);
      add_load(SIZE_HALF, 1'b1, 32'h11, 1'b1);
      add_load(SIZE_WORD, 1'b0, 32'h13, 1'b1);
      add_load(SIZE_WORD, 1'b0, 32'h12, 1'b1);
      // Stalled load and store, accepted once stall drops
      add_load(SIZE_WORD, 1'b0, 32'h10, 1'b0);
      add_row(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, SIZE_WORD, 32'h14, 1'b0);
      add_row(1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0, SIZE_WORD, 32'h14, 1'b0);
      add_load(SIZE_WORD, 1'b0, 32'h14, 1'b0);
      add_row(1'b1, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0, SIZE_WORD, 32'h18, 1'b0);
      add_load(SIZE_WORD, 1'b0, 32'h18, 1'b0);   // Old word still in place
      add_store(SIZE_WORD, 32'h18, 1'b0);
      add_load(SIZE_WORD, 1'b0, 32'h18, 1'b0);
      // Flushed and invalid requests
      add_row(1'b1, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, SIZE_WORD, 32'h1C, 1'b0);
      add_row(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0, SIZE_WORD, 32'h1C, 1'b0);
      add_row(1'b1, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0, SIZE_WORD, 32'h1C, 1'b0);
      add_load(SIZE_WORD, 1'b0, 32'h1C, 1'b0);
      add_load(SIZE_WORD, 1'b0, 32'h400, 1'b0);   // Aliases word 0
   endtask

   initial begin
      int n;
      int wait_cycles;
      int table_cycles;
      void'($urandom(32'h63));
      stall          = 1'b0;
      flush          = 1'b0;
      ex_valid       = 1'b0;
      ex_lsu_opc_bus = '0;
      add_sum        = '0;
      ex_operand2    = '0;
      exp_valid      = 1'b0;
      exp_ealign     = 1'b0;
      exp_vaddr      = '0;
      exp_dout       = '0;
      vaddr_known    = 1'b0;
      dout_known     = 1'b0;
      build_table();
      n = rows.size();

      wait_cycles = 0;
      while (rst !== 1'b0) begin
         @(posedge clk);
         wait_cycles++;
         if (wait_cycles > 20) begin
            $display("Reset was never released");
            $display("RESULT: FAIL");
            $fatal(1, "Reset timeout");
         end
      end
      #1;
      check_bit("lsu_valid", 1'b0, lsu_valid);
      check_bit("lsu_ealign", 1'b0, lsu_ealign);

      table_cycles = 0;
      for (int i = 0; i <= n; i++) begin
         @(posedge clk);
         #1;
         table_cycles++;
         if (table_cycles > n + 10) begin
            $display("Stimulus table ran past its cycle budget");
            $display("RESULT: FAIL");
            $fatal(1, "Table timeout");
         end
         if (i > 0)
            check_outputs();   // Results of the row driven one cycle earlier
         if (i < n)
            apply_row(rows[i]);
      end

      $display("RESULT: PASS");
      $finish;
   end

endmodule

/* ex_lsu.f */
hdl/ex_lsu_pkg.sv
hdl/lsu_ctrl.sv
hdl/lsu_store_fmt.sv
hdl/lsu_dmem.sv
hdl/lsu_load_fmt.sv
hdl/ex_lsu.sv
test/ex_lsu_props.sv
test/tb_ex_lsu.sv

/* Makefile */
# Verilator build and run of the LSU testbench

TOP = tb_ex_lsu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f ex_lsu.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir
